/* rtcPkg.sv */
`default_nettype none

package rtcPkg;

	// bus and register file widths
	localparam int DATA_W = 8;
	localparam int ADDR_W = 7;
	localparam int SLOT_W = 3;

	typedef logic [DATA_W-1:0] rtcData_t;
	typedef logic [ADDR_W-1:0] rtcAddr_t;
	typedef logic [SLOT_W-1:0] rtcSlot_t;

	// phase lengths in clock cycles
	localparam logic [2:0] ADDR_CYCLES = 3'd2;
	localparam logic [2:0] DATA_CYCLES = 3'd3;
	localparam logic [2:0] RECOVER_CYCLES = 3'd1;

	// time registers, seconds first, consecutive chip addresses
	localparam int TIME_SLOTS = 6;
	localparam rtcAddr_t TIME_BASE = 7'd0;

	// configuration written once after reset
	localparam rtcAddr_t CFG_A_ADDR = 7'd10;
	localparam rtcData_t CFG_A_VAL = 8'h20;
	localparam rtcAddr_t CFG_B_ADDR = 7'd11;
	localparam rtcData_t CFG_B_VAL = 8'h02;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} rtcOp_e;

	// main sequencer states
	typedef enum logic [2:0] {
		ST_INIT_A,
		ST_INIT_B,
		ST_POLL,
		ST_SET,
		ST_WAIT
	} rtcState_e;

	// phases of one chip bus access
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_ADDR,
		PH_DATA,
		PH_RECOVER
	} rtcPhase_e;

endpackage

`default_nettype wire

/* rtcBusIf.sv */
`timescale 1ns/1ns
`default_nettype none

// one access request from the sequencer, result back from the cycle engine
interface rtcBusIf import rtcPkg::*; ();

	logic start;
	rtcOp_e op;
	rtcAddr_t addr;
	rtcData_t wdata;
	rtcData_t rdata;
	logic done;

	modport fsm (
		output start,
		output op,
		output addr,
		output wdata,
		input rdata,
		input done
	);

	modport cycle (
		input start,
		input op,
		input addr,
		input wdata,
		output rdata,
		output done
	);

endinterface

`default_nettype wire

/* rtcPhaseTimer.sv */
`timescale 1ns/1ns
`default_nettype none

module rtcPhaseTimer (
	input wire logic clk,
	input wire logic rstN,
	input wire logic load,
	input wire logic [2:0] loadValue,
	output logic expired
);

	logic [2:0] count;

	// a load of N gives N cycles, the last one flagged
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			count <= 3'd0;
		end else if (load) begin
			count <= loadValue - 3'd1;
		end else if (count != 3'd0) begin
			count <= count - 3'd1;
		end
	end

	// also high while nothing is loaded, the engine ignores it then
	assign expired = (count == 3'd0);

endmodule

`default_nettype wire

/* rtcBusCycle.sv */
`timescale 1ns/1ns
`default_nettype none

module rtcBusCycle import rtcPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	rtcBusIf.cycle bus,
	input wire rtcData_t busIn,
	output rtcData_t busOut,
	output logic busOe,
	output logic cs,
	output logic ad,
	output logic rd,
	output logic wr
);

	rtcPhase_e phase;
	rtcPhase_e phaseNext;
	logic timerLoad;
	logic [2:0] timerValue;
	logic timerExpired;
	logic isRead;
	rtcData_t rdataQ;

	assign isRead = (bus.op == OP_READ);

	rtcPhaseTimer u_phaseTimer (
		.clk(clk),
		.rstN(rstN),
		.load(timerLoad),
		.loadValue(timerValue),
		.expired(timerExpired)
	);

	// each phase loads the timer with its own length on entry
	always_comb begin
		phaseNext = phase;
		timerLoad = 1'b0;
		timerValue = ADDR_CYCLES;
		case (phase)
			PH_IDLE: begin
				if (bus.start) begin
					phaseNext = PH_ADDR;
					timerLoad = 1'b1;
					timerValue = ADDR_CYCLES;
				end
			end
			PH_ADDR: begin
				if (timerExpired) begin
					phaseNext = PH_DATA;
					timerLoad = 1'b1;
					timerValue = DATA_CYCLES;
				end
			end
			PH_DATA: begin
				if (timerExpired) begin
					phaseNext = PH_RECOVER;
					timerLoad = 1'b1;
					timerValue = RECOVER_CYCLES;
				end
			end
			PH_RECOVER: begin
				if (timerExpired) begin
					phaseNext = PH_IDLE;
				end
			end
			default: phaseNext = PH_IDLE;
		endcase
	end

	// strobes follow the next phase so they change right on the edge
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			phase <= PH_IDLE;
			cs <= 1'b1;
			ad <= 1'b0;
			rd <= 1'b1;
			wr <= 1'b1;
			busOe <= 1'b0;
		end else begin
			phase <= phaseNext;
			cs <= !((phaseNext == PH_ADDR) || (phaseNext == PH_DATA));
			ad <= (phaseNext == PH_ADDR);
			rd <= !((phaseNext == PH_DATA) && isRead);
			wr <= !((phaseNext == PH_DATA) && !isRead);
			busOe <= (phaseNext == PH_ADDR) || ((phaseNext == PH_DATA) && !isRead);
		end
	end

	// write data held through recovery so it is stable when wr rises
	always_comb begin
		case (phase)
			PH_ADDR: busOut = rtcData_t'(bus.addr);
			PH_DATA, PH_RECOVER: busOut = bus.wdata;
			default: busOut = '0;
		endcase
	end

	// sample in the last rd-low cycle
	always_ff @(posedge clk) begin
		if ((phase == PH_DATA) && timerExpired && isRead) begin
			rdataQ <= busIn;
		end
	end

	assign bus.rdata = rdataQ;
	assign bus.done = (phase == PH_RECOVER) && timerExpired;

endmodule

`default_nettype wire

/* rtcMainFsm.sv */
`timescale 1ns/1ns
`default_nettype none

module rtcMainFsm import rtcPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic setReq,
	input wire rtcAddr_t setAddr,
	input wire rtcData_t setData,
	rtcBusIf.fsm bus,
	output logic slotWrEn,
	output rtcSlot_t slot
);

	rtcState_e state;
	logic busy;
	logic issue;
	logic cfgDone;
	logic pending;
	rtcAddr_t setAddrQ;
	rtcData_t setDataQ;

	// states that own a bus access
	assign issue = (state == ST_INIT_A) || (state == ST_INIT_B) ||
		(state == ST_POLL) || (state == ST_SET);

	// one pulse per access, only while the engine is idle
	assign bus.start = issue && !busy;

	assign slotWrEn = (state == ST_POLL) && bus.done;

	// request fields stay put for the whole access
	always_comb begin
		bus.op = OP_WRITE;
		bus.addr = CFG_A_ADDR;
		bus.wdata = CFG_A_VAL;
		case (state)
			ST_INIT_B: begin
				bus.addr = CFG_B_ADDR;
				bus.wdata = CFG_B_VAL;
			end
			ST_POLL: begin
				bus.op = OP_READ;
				bus.addr = TIME_BASE + rtcAddr_t'(slot);
				bus.wdata = '0;
			end
			ST_SET: begin
				bus.addr = setAddrQ;
				bus.wdata = setDataQ;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= ST_INIT_A;
			busy <= 1'b0;
			cfgDone <= 1'b0;
		end else begin
			if (bus.start) begin
				busy <= 1'b1;
			end else if (bus.done) begin
				busy <= 1'b0;
			end
			case (state)
				ST_INIT_A: begin
					if (bus.done) begin
						state <= ST_WAIT;
					end
				end
				ST_INIT_B: begin
					if (bus.done) begin
						cfgDone <= 1'b1;
						state <= ST_WAIT;
					end
				end
				ST_POLL, ST_SET: begin
					if (bus.done) begin
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					// pending host write goes ahead of the next poll read
					if (!cfgDone) begin
						state <= ST_INIT_B;
					end else if (pending) begin
						state <= ST_SET;
					end else begin
						state <= ST_POLL;
					end
				end
				default: state <= ST_INIT_A;
			endcase
		end
	end

	// poll slot, wraps after the year register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			slot <= '0;
		end else if (slotWrEn) begin
			if (slot == rtcSlot_t'(TIME_SLOTS - 1)) begin
				slot <= '0;
			end else begin
				slot <= slot + 3'd1;
			end
		end
	end

	// one-entry set latch, new requests dropped while full
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pending <= 1'b0;
		end else if (setReq && !pending) begin
			pending <= 1'b1;
		end else if ((state == ST_SET) && bus.done) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (setReq && !pending) begin
			setAddrQ <= setAddr;
			setDataQ <= setData;
		end
	end

endmodule

`default_nettype wire

/* rtcTimeRegs.sv */
`timescale 1ns/1ns
`default_nettype none

module rtcTimeRegs import rtcPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic wrEn,
	input wire rtcSlot_t slot,
	input wire rtcData_t wdata,
	input wire rtcSlot_t regSel,
	output rtcData_t timeOut,
	output logic timeValid
);

	rtcData_t regs [TIME_SLOTS];

	// cleared so the host sees zero until the first sweep lands
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < TIME_SLOTS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (int'(slot) < TIME_SLOTS)) begin
			regs[slot] <= wdata;
		end
	end

	// sticky once the year slot has been filled
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			timeValid <= 1'b0;
		end else if (wrEn && (slot == rtcSlot_t'(TIME_SLOTS - 1))) begin
			timeValid <= 1'b1;
		end
	end

	// host read port, slots past the year read as zero
	assign timeOut = (int'(regSel) < TIME_SLOTS) ? regs[regSel] : '0;

endmodule

`default_nettype wire

/* rtcController.sv */
`timescale 1ns/1ns
`default_nettype none

module rtcController import rtcPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic setReq,
	input wire rtcAddr_t setAddr,
	input wire rtcData_t setData,
	input wire rtcSlot_t regSel,
	output rtcData_t timeOut,
	output logic timeValid,
	input wire rtcData_t busIn,
	output rtcData_t busOut,
	output logic busOe,
	output logic cs,
	output logic ad,
	output logic rd,
	output logic wr
);

	logic slotWrEn;
	rtcSlot_t slot;

	// access request and result between sequencer and cycle engine
	rtcBusIf busIf ();

	rtcMainFsm u_mainFsm (
		.clk(clk),
		.rstN(rstN),
		.setReq(setReq),
		.setAddr(setAddr),
		.setData(setData),
		.bus(busIf.fsm),
		.slotWrEn(slotWrEn),
		.slot(slot)
	);

	rtcBusCycle u_busCycle (
		.clk(clk),
		.rstN(rstN),
		.bus(busIf.cycle),
		.busIn(busIn),
		.busOut(busOut),
		.busOe(busOe),
		.cs(cs),
		.ad(ad),
		.rd(rd),
		.wr(wr)
	);

	// poll results go straight from the engine into the register file
	rtcTimeRegs u_timeRegs (
		.clk(clk),
		.rstN(rstN),
		.wrEn(slotWrEn),
		.slot(slot),
		.wdata(busIf.rdata),
		.regSel(regSel),
		.timeOut(timeOut),
		.timeValid(timeValid)
	);

endmodule

`default_nettype wire

/* rtcController_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module rtcController_chk (
	input wire logic clk,
	input wire logic rstN,
	input wire logic cs,
	input wire logic ad,
	input wire logic rd,
	input wire logic wr,
	input wire logic busOe
);

	int failCount = 0;

	rdWrApart: assert property (@(posedge clk) disable iff (!rstN) rd || wr)
		else begin
			failCount = failCount + 1;
			$error("rd and wr low in the same cycle");
		end

	// a strobe only inside a selected access
	strobeNeedsCs: assert property (@(posedge clk) disable iff (!rstN) (!rd || !wr) |-> !cs)
		else begin
			failCount = failCount + 1;
			$error("rd or wr low while cs is high");
		end

	adOffInStrobe: assert property (@(posedge clk) disable iff (!rstN) (!rd || !wr) |-> !ad)
		else begin
			failCount = failCount + 1;
			$error("ad high during a data strobe");
		end

	// chip owns the bus while rd is low
	readReleasesBus: assert property (@(posedge clk) disable iff (!rstN) !rd |-> !busOe)
		else begin
			failCount = failCount + 1;
			$error("busOe high during a read strobe");
		end

endmodule

`default_nettype wire

/* tbRtcController.sv */
`timescale 1ns/1ns
`default_nettype none

module tbRtcController import rtcPkg::*; ();

	localparam int WAIT_LIMIT = 500;

	logic clk;
	logic rstN;
	logic setReq;
	rtcAddr_t setAddr;
	rtcData_t setData;
	rtcSlot_t regSel;
	rtcData_t timeOut;
	logic timeValid;
	rtcData_t busIn;
	rtcData_t busOut;
	logic busOe;
	logic cs;
	logic ad;
	logic rd;
	logic wr;

	// chip model and stimulus lists
	rtcData_t mem [128];
	rtcAddr_t addrShadow;
	rtcAddr_t latchAddr;
	rtcOp_e lastOp;
	rtcAddr_t setAddrQ [$];
	rtcData_t setDataQ [$];
	rtcSlot_t expSlotQ [$];
	rtcData_t expDataQ [$];

	rtcController u_rtcController (
		.clk(clk),
		.rstN(rstN),
		.setReq(setReq),
		.setAddr(setAddr),
		.setData(setData),
		.regSel(regSel),
		.timeOut(timeOut),
		.timeValid(timeValid),
		.busIn(busIn),
		.busOut(busOut),
		.busOe(busOe),
		.cs(cs),
		.ad(ad),
		.rd(rd),
		.wr(wr)
	);

	bind rtcController rtcController_chk u_chk (
		.clk(clk),
		.rstN(rstN),
		.cs(cs),
		.ad(ad),
		.rd(rd),
		.wr(wr),
		.busOe(busOe)
	);

	always #2 clk = ~clk;

	// address seen on the bus while ad is high, taken over when ad falls
	always @(posedge clk) begin
		if (ad) begin
			addrShadow <= rtcAddr_t'(busOut);
		end
	end

	always @(negedge ad) begin
		latchAddr <= addrShadow;
	end

	always @(negedge rd or negedge wr) begin
		if (rstN) begin
			lastOp <= rd ? OP_WRITE : OP_READ;
		end
	end

	assign busIn = !rd ? mem[latchAddr] : 8'hFF;

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkByte(input string name, input rtcData_t expected, input rtcData_t actual);
		if (actual !== expected) begin
			stopRun($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stopRun($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
		end
	endtask

	task automatic stepCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic loadStim();
		int fd;
		int n;
		string line;
		byte kind;
		int a;
		int d;
		fd = $fopen("rtc_stim.txt", "r");
		if (fd == 0) begin
			stopRun("could not open rtc_stim.txt");
		end
		// background pattern for bytes that the file leaves alone
		for (int i = 0; i < 128; i++) begin
			mem[i] = rtcData_t'(i * 37 + 11);
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%c %h %h", kind, a, d);
			if (n == 3) begin
				case (kind)
					"M": mem[a] = rtcData_t'(d);
					"S": begin
						setAddrQ.push_back(rtcAddr_t'(a));
						setDataQ.push_back(rtcData_t'(d));
					end
					"E": begin
						expSlotQ.push_back(rtcSlot_t'(a));
						expDataQ.push_back(rtcData_t'(d));
					end
					default: begin
					end
				endcase
			end
		end
		$fclose(fd);
	endtask

	// chip model: file contents first, then writes on each rising wr
	initial begin
		loadStim();
		forever begin
			@(posedge wr);
			if (rstN) begin
				mem[latchAddr] = busOut;
			end
		end
	end

	task automatic awaitTimeValid();
		int n;
		n = 0;
		while (timeValid !== 1'b1) begin
			if (n == WAIT_LIMIT) begin
				stopRun("timed out waiting for timeValid to rise");
			end
			stepCycle();
			n++;
		end
	endtask

	task automatic watchModelByte(input rtcAddr_t addr, input rtcData_t data);
		int n;
		n = 0;
		while (mem[addr] !== data) begin
			if (n == WAIT_LIMIT) begin
				stopRun($sformatf("timed out waiting for chip write at address %h", addr));
			end
			stepCycle();
			n++;
		end
	endtask

	task automatic settleTimeOut(input rtcData_t data);
		int n;
		n = 0;
		while (timeOut !== data) begin
			if (n == WAIT_LIMIT) begin
				stopRun($sformatf("timed out waiting for timeOut at slot %0d", regSel));
			end
			stepCycle();
			n++;
		end
	endtask

	// an access in flight, so a request lands while the engine is busy
	task automatic catchNextAccess();
		int n;
		n = 0;
		while (cs !== 1'b0) begin
			if (n == WAIT_LIMIT) begin
				stopRun("timed out waiting for the next bus access");
			end
			stepCycle();
			n++;
		end
	endtask

	// let the access in flight end, then stop at the next rd or wr strobe
	task automatic skipToNextStrobe();
		int n;
		n = 0;
		while (cs !== 1'b1) begin
			if (n == WAIT_LIMIT) begin
				stopRun("timed out waiting for the access in flight to end");
			end
			stepCycle();
			n++;
		end
		n = 0;
		while ((rd !== 1'b0) && (wr !== 1'b0)) begin
			if (n == WAIT_LIMIT) begin
				stopRun("timed out waiting for the next rd or wr strobe");
			end
			stepCycle();
			n++;
		end
	endtask

	task automatic issueSet(input rtcAddr_t addr, input rtcData_t data);
		catchNextAccess();
		setReq = 1'b1;
		setAddr = addr;
		setData = data;
		stepCycle();
		setReq = 1'b0;
		skipToNextStrobe();
		checkFlag("set ahead of next poll", 1'b1, lastOp == OP_WRITE);
		watchModelByte(addr, data);
		if ((addr >= TIME_BASE) && (int'(addr - TIME_BASE) < TIME_SLOTS)) begin
			regSel = rtcSlot_t'(addr - TIME_BASE);
			settleTimeOut(data);
		end
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b1;
		setReq = 1'b0;
		setAddr = '0;
		setData = '0;
		regSel = '0;
		#1 rstN = 1'b0;
		repeat (3) @(posedge clk);
		#1 rstN = 1'b1;
		checkFlag("reset cs", 1'b1, cs);
		checkFlag("reset rd", 1'b1, rd);
		checkFlag("reset wr", 1'b1, wr);
		checkFlag("reset ad", 1'b0, ad);
		checkFlag("reset busOe", 1'b0, busOe);
		checkFlag("reset timeValid", 1'b0, timeValid);
		checkByte("reset timeOut", 8'h00, timeOut);

		awaitTimeValid();
		checkByte("init cfg A", CFG_A_VAL, mem[CFG_A_ADDR]);
		checkByte("init cfg B", CFG_B_VAL, mem[CFG_B_ADDR]);

		foreach (expSlotQ[i]) begin
			regSel = expSlotQ[i];
			stepCycle();
			checkByte($sformatf("poll model slot %0d", expSlotQ[i]), expDataQ[i],
				mem[TIME_BASE + rtcAddr_t'(expSlotQ[i])]);
			checkByte($sformatf("poll slot %0d", expSlotQ[i]), expDataQ[i], timeOut);
		end

		foreach (setAddrQ[i]) begin
			issueSet(setAddrQ[i], setDataQ[i]);
		end

		for (int s = TIME_SLOTS; s < 8; s++) begin
			regSel = rtcSlot_t'(s);
			stepCycle();
			checkByte($sformatf("out of range slot %0d", s), 8'h00, timeOut);
		end

		stepCycle();
		if (u_rtcController.u_chk.failCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtc_stim.txt */
# M addr data : chip model byte, S addr data : host set, E slot data : expected timeOut
# all numbers hex
M 00 45
M 01 30
M 02 12
M 03 17
M 04 06
M 05 24
M 0a 00
M 0b 00
E 0 45
E 1 30
E 2 12
E 3 17
E 4 06
E 5 24
S 14 5a
S 01 59
S 05 25
S 30 a7

/* flist.f */
rtcPkg.sv
rtcBusIf.sv
rtcPhaseTimer.sv
rtcBusCycle.sv
rtcMainFsm.sv
rtcTimeRegs.sv
rtcController.sv
rtcController_chk.sv
tbRtcController.sv

/* Makefile */
TOP = tbRtcController

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
